// File: Makefile
TOP := tb_vregunpack

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f sim.f --top-module $(TOP)
	verilator --lint-only -Wno-fatal vregunpack_pkg.sv op_lane_if.sv unpack_stage_ctrl.sv \
		data_operand_unpack.sv mask_operand_unpack.sv vregunpack_top.sv \
		--top-module vregunpack_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: data_operand_unpack.sv
/*
 * data operand unpack unit
 * keeps the operand a buffer and extracts a 32-bit operand with
 * narrow extension or scalar broadcast
 */
module data_operand_unpack import vregunpack_pkg::*; (
    input  logic    clk_i,
    input  logic    async_rst_ni,
    op_lane_if.lane lane
);

    localparam int unsigned HALF_W = OP_W / 2;

    vreg_data_t opbuf_q;
    vreg_data_t opbuf_d;
    op_data_t   ext_data;
    op_data_t   data_q;
    logic       sig;

    // load wins over shift, shift wins over narrow
    always_comb begin
        opbuf_d = opbuf_q;
        if (lane.load_flags[A_LOAD]) begin
            opbuf_d = lane.vreg_data;
        end else if (lane.load_flags[A_SHIFT]) begin
            opbuf_d = {{OP_W{1'b0}}, opbuf_q[VREG_W-1:OP_W]};
        end else if (lane.load_flags[A_NARROW]) begin
            // upper half of the narrow operand moves down for the next item
            opbuf_d[HALF_W-1:0] = opbuf_q[OP_W-1:HALF_W];
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            opbuf_q <= '0;
        end else if (lane.load_en) begin
            opbuf_q <= opbuf_d;
        end
    end

    assign sig = lane.extract_flags[A_SIGEXT];

    always_comb begin
        ext_data = opbuf_q[OP_W-1:0];
        if (!lane.extract_flags[A_VREG]) begin
            // scalar repeated over every element
            unique case (lane.extract_eew)
                VSEW_8: begin
                    ext_data = {4{lane.extract_xval[7:0]}};
                end
                VSEW_16: begin
                    ext_data = {2{lane.extract_xval[15:0]}};
                end
                default: begin
                    ext_data = lane.extract_xval;
                end
            endcase
        end else if (lane.extract_flags[A_NARROW]) begin
            unique case (lane.extract_eew)
                VSEW_16: begin
                    // two bytes widened to halfwords
                    for (int j = 0; j < 2; j++) begin
                        ext_data[16*j +: 16] = {{8{sig & opbuf_q[8*j+7]}}, opbuf_q[8*j +: 8]};
                    end
                end
                VSEW_32: begin
                    ext_data = {{16{sig & opbuf_q[15]}}, opbuf_q[15:0]};
                end
                default: begin
                    ext_data = opbuf_q[OP_W-1:0];
                end
            endcase
        end
    end

    // result register of the output stage
    always_ff @(posedge clk_i) begin
        if (lane.capture_en) begin
            data_q <= ext_data;
        end
    end

    assign lane.op_data = data_q;

endmodule

// File: mask_operand_unpack.sv
/*
 * mask operand unpack unit
 * keeps the element mask buffer and widens it to a byte mask
 */
module mask_operand_unpack import vregunpack_pkg::*; (
    input  logic    clk_i,
    input  logic    async_rst_ni,
    op_lane_if.lane lane
);

    vreg_data_t mbuf_q;
    vreg_data_t mbuf_d;
    op_data_t   byte_mask;

    // one item consumes 32, 16 or 8 mask bits depending on element width
    always_comb begin
        mbuf_d = mbuf_q;
        if (lane.load_flags[M_LOAD]) begin
            mbuf_d = lane.vreg_data;
        end else if (lane.load_flags[M_SHIFT]) begin
            unique case (lane.load_eew)
                VSEW_8:  mbuf_d = mbuf_q >> 32;
                VSEW_16: mbuf_d = mbuf_q >> 16;
                VSEW_32: mbuf_d = mbuf_q >> 8;
                default: mbuf_d = mbuf_q;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            mbuf_q <= '0;
        end else if (lane.load_en) begin
            mbuf_q <= mbuf_d;
        end
    end

    // element mask bit copied to every byte of its element
    always_comb begin
        byte_mask = '0;
        unique case (lane.extract_eew)
            VSEW_8: begin
                byte_mask = mbuf_q[OP_W-1:0];
            end
            VSEW_16: begin
                for (int j = 0; j < OP_W / 2; j++) begin
                    byte_mask[2*j +: 2] = {2{mbuf_q[j]}};
                end
            end
            VSEW_32: begin
                for (int j = 0; j < OP_W / 4; j++) begin
                    byte_mask[4*j +: 4] = {4{mbuf_q[j]}};
                end
            end
            default: begin
                byte_mask = '0;
            end
        endcase
    end

    assign lane.op_data = byte_mask;

endmodule

// File: op_lane_if.sv
/*
 * operand lane interface
 * links the unpack stage controller to one operand buffer unit
 */
interface op_lane_if import vregunpack_pkg::*; ();

    // load stage side
    logic       load_en;
    // mask flags arrive zero-extended to the data flag width
    a_flags_t   load_flags;
    vsew_e      load_eew;
    vreg_data_t vreg_data;

    // extract stage side
    a_flags_t   extract_flags;
    vsew_e      extract_eew;
    xval_t      extract_xval;
    logic       capture_en;

    op_data_t   op_data;

    modport ctrl (
        output load_en, load_flags, load_eew, vreg_data,
        output extract_flags, extract_eew, extract_xval, capture_en
    );

    modport lane (
        input  load_en, load_flags, load_eew, vreg_data,
        input  extract_flags, extract_eew, extract_xval, capture_en,
        output op_data
    );

endinterface

// File: sim.f
vregunpack_pkg.sv
op_lane_if.sv
unpack_stage_ctrl.sv
data_operand_unpack.sv
mask_operand_unpack.sv
vregunpack_top.sv
vregunpack_chk.sv
tb_vregunpack.sv

// File: tb_vregunpack.sv
/*
 * testbench for the vector register unpack pipeline
 * table driven stimulus with a reference model of both operand buffers
 */
module tb_vregunpack import vregunpack_pkg::*; ();

    typedef struct packed {
        ctrl_t      ctrl;
        logic [1:0] eew;
        a_flags_t   af;
        m_flags_t   mf;
        vaddr_t     av;
        vaddr_t     mv;
        xval_t      xv;
        logic       stall;
    } item_t;
    typedef struct packed {
        ctrl_t       ctrl;
        op_data_t    a;
        op_data_t    m;
        logic        lat;
        logic [31:0] cyc;
    } exp_t;

    logic clk_i = 1'b0;
    logic async_rst_ni, pipe_in_valid_i, pipe_in_ready_o, pipe_out_valid_o, pipe_out_ready_i;
    ctrl_t pipe_in_ctrl_i, pipe_out_ctrl_o;
    vsew_e pipe_in_eew_i;
    a_flags_t pipe_in_a_flags_i;
    m_flags_t pipe_in_m_flags_i;
    vaddr_t pipe_in_a_vaddr_i, pipe_in_m_vaddr_i, vreg_a_rd_addr_o, vreg_m_rd_addr_o;
    xval_t pipe_in_a_xval_i;
    op_data_t pipe_out_a_data_o, pipe_out_m_data_o;
    vreg_data_t vreg_a_rd_data_i, vreg_m_rd_data_i;
    vreg_mask_t pending_vreg_reads_o;
    logic stage_valid_any_o;

    item_t tbl[$];
    exp_t exp_q[$];
    logic [63:0] abuf = '0;
    logic [63:0] mbuf = '0;
    logic [31:0] cyc = '0;
    int rdy_mode = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed = 0;

    vregunpack_top DUT (.*);

    always #5 clk_i = ~clk_i;

    // register file contents with every byte depending on the address
    function automatic logic [63:0] reg_pat(input vaddr_t addr);
        logic [63:0] v;
        for (int k = 0; k < 8; k++) begin
            v[8*k +: 8] = 8'(addr * 37 + k * 29 + 133);
        end
        return v;
    endfunction

    assign vreg_a_rd_data_i = reg_pat(vreg_a_rd_addr_o);
    assign vreg_m_rd_data_i = reg_pat(vreg_m_rd_addr_o);

    // mode 0 always ready, 1 random, 2 held low
    always @(negedge clk_i) begin
        cyc = cyc + 1;
        case (rdy_mode)
            0: pipe_out_ready_i = 1'b1;
            1: pipe_out_ready_i = 1'($urandom % 2);
            default: pipe_out_ready_i = 1'b0;
        endcase
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk_i) begin
        exp_t e;
        if (async_rst_ni && pipe_out_valid_o && pipe_out_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error: output transferred an item that was never sent");
            end else begin
                e = exp_q.pop_front();
                check_val("pipe_out_ctrl_o", 64'(pipe_out_ctrl_o), 64'(e.ctrl));
                check_val("pipe_out_a_data_o", 64'(pipe_out_a_data_o), 64'(e.a));
                check_val("pipe_out_m_data_o", 64'(pipe_out_m_data_o), 64'(e.m));
                if (e.lat) begin
                    check_val("latency", 64'(cyc - e.cyc), 64'd2);
                end
            end
        end
    end

    // reference model applied once per accepted item in order
    task automatic predict(input item_t it, input logic lat);
        exp_t e;
        logic [31:0] w;
        logic sig;
        sig = it.af[A_SIGEXT];
        if (it.af[A_LOAD]) abuf = reg_pat(it.af[A_VREG] ? it.av : 5'd0);
        else if (it.af[A_SHIFT]) abuf = abuf >> 32;
        else if (it.af[A_NARROW]) abuf[15:0] = abuf[31:16];
        w = abuf[31:0];
        e.a = w;
        if (!it.af[A_VREG]) begin
            e.a = (it.eew == 2'd0) ? {4{it.xv[7:0]}} :
                  (it.eew == 2'd1) ? {2{it.xv[15:0]}} : it.xv;
        end else if (it.af[A_NARROW] && it.eew == 2'd1) begin
            e.a[15:0]  = sig ? 16'($signed(w[7:0])) : 16'(w[7:0]);
            e.a[31:16] = sig ? 16'($signed(w[15:8])) : 16'(w[15:8]);
        end else if (it.af[A_NARROW] && it.eew == 2'd2) begin
            e.a = sig ? 32'($signed(w[15:0])) : 32'(w[15:0]);
        end
        if (it.mf[M_LOAD]) mbuf = reg_pat(it.mv);
        else if (it.mf[M_SHIFT]) mbuf = mbuf >> (32 >> it.eew);
        // byte b belongs to element b >> eew
        for (int b = 0; b < 32; b++) begin
            e.m[b] = mbuf[b >> it.eew];
        end
        e.ctrl = it.ctrl;
        e.lat = lat;
        e.cyc = cyc;
        exp_q.push_back(e);
    endtask

    task automatic add_item(input logic [1:0] eew, input a_flags_t af, input m_flags_t mf,
                            input vaddr_t av, input vaddr_t mv, input logic stall);
        item_t it;
        it = '{ctrl: 8'(tbl.size() * 7 + 1), eew: eew, af: af, mf: mf, av: av, mv: mv,
               xv: $urandom, stall: stall};
        tbl.push_back(it);
    endtask

    task automatic drive_item(input item_t it);
        pipe_in_ctrl_i    = it.ctrl;
        pipe_in_eew_i     = vsew_e'(it.eew);
        pipe_in_a_flags_i = it.af;
        pipe_in_m_flags_i = it.mf;
        pipe_in_a_vaddr_i = it.av;
        pipe_in_m_vaddr_i = it.mv;
        pipe_in_a_xval_i  = it.xv;
        pipe_in_valid_i   = 1'b1;
    endtask

    // called just after a falling edge
    // mode -1 takes the stall flag of the table entry
    task automatic send_item(input int idx, input int mode, input logic lat);
        int t;
        vaddr_t a_addr;
        t = 0;
        // register 0 is read unless the item loads a vector register
        a_addr = '0;
        if (tbl[idx].af[A_LOAD] && tbl[idx].af[A_VREG]) begin
            a_addr = tbl[idx].av;
        end
        rdy_mode = (mode < 0) ? (tbl[idx].stall ? 1 : 0) : mode;
        drive_item(tbl[idx]);
        do begin
            @(posedge clk_i);
            t++;
        end while (!pipe_in_ready_o && t < 200);
        if (pipe_in_ready_o) begin
            check_val("vreg_a_rd_addr_o", 64'(vreg_a_rd_addr_o), 64'(a_addr));
            predict(tbl[idx], lat);
        end else begin
            errors++;
            $display("Error: item %0d was not accepted within 200 cycles", idx);
        end
        @(negedge clk_i);
        pipe_in_valid_i = 1'b0;
    endtask

    task automatic send_range(input int lo, input int hi, input int mode, input logic lat);
        for (int i = lo; i <= hi; i++) begin
            send_item(i, mode, lat);
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        rdy_mode = 0;
        while ((exp_q.size() != 0 || stage_valid_any_o) && t < 200) begin
            @(negedge clk_i);
            t++;
        end
        if (t >= 200) begin
            errors++;
            $display("Error: pipeline did not drain within 200 cycles");
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) failed++;
        $display("test %s: %s", name, (errors == err_before) ? "pass" : "FAIL");
    endtask

    initial begin
        int e0;
        vreg_mask_t pexp;
        void'($urandom(94275));
        async_rst_ni = 1'b0;
        pipe_out_ready_i = 1'b1;
        drive_item('0);
        pipe_in_valid_i = 1'b0;
        // a flag literals are {vreg, sigext, narrow, shift, load}
        add_item(2'd0, 5'b10000, 2'b00, 5'd11, 5'd23, 1'b0);
        add_item(2'd2, 5'b10001, 2'b01, 5'd3, 5'd9, 1'b0);
        add_item(2'd2, 5'b10010, 2'b10, 5'd0, 5'd0, 1'b1);
        add_item(2'd1, 5'b10101, 2'b10, 5'd7, 5'd0, 1'b0);
        add_item(2'd1, 5'b11100, 2'b00, 5'd0, 5'd0, 1'b1);
        add_item(2'd2, 5'b11101, 2'b00, 5'd13, 5'd0, 1'b0);
        add_item(2'd2, 5'b10100, 2'b00, 5'd0, 5'd0, 1'b1);
        add_item(2'd0, 5'b00000, 2'b00, 5'd0, 5'd0, 1'b0);
        add_item(2'd1, 5'b00000, 2'b00, 5'd0, 5'd0, 1'b1);
        add_item(2'd2, 5'b00000, 2'b00, 5'd0, 5'd0, 1'b0);
        add_item(2'd0, 5'b10000, 2'b01, 5'd0, 5'd20, 1'b0);
        add_item(2'd0, 5'b10000, 2'b10, 5'd0, 5'd0, 1'b1);
        add_item(2'd1, 5'b10000, 2'b01, 5'd0, 5'd27, 1'b0);
        add_item(2'd1, 5'b10000, 2'b10, 5'd0, 5'd0, 1'b1);
        add_item(2'd1, 5'b10000, 2'b10, 5'd0, 5'd0, 1'b0);
        add_item(2'd2, 5'b10000, 2'b01, 5'd0, 5'd14, 1'b1);
        add_item(2'd2, 5'b10000, 2'b10, 5'd0, 5'd0, 1'b0);
        add_item(2'd2, 5'b10000, 2'b10, 5'd0, 5'd0, 1'b1);
        add_item(2'd0, 5'b10001, 2'b01, 5'd1, 5'd2, 1'b0);
        add_item(2'd1, 5'b10001, 2'b01, 5'd4, 5'd5, 1'b0);
        add_item(2'd2, 5'b10001, 2'b01, 5'd6, 5'd8, 1'b0);

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;

        e0 = errors;
        check_val("pipe_out_valid_o", 64'(pipe_out_valid_o), 64'd0);
        check_val("stage_valid_any_o", 64'(stage_valid_any_o), 64'd0);
        check_val("pending_vreg_reads_o", 64'(pending_vreg_reads_o), 64'd0);
        send_item(0, 0, 1'b0);
        // item 0 now sits in the mask load stage without a mask load
        check_val("vreg_m_rd_addr_o", 64'(vreg_m_rd_addr_o), 64'd0);
        drain();
        end_test("reset state", e0);

        e0 = errors;
        send_range(1, 9, -1, 1'b0);
        drain();
        end_test("data operand sequences", e0);

        e0 = errors;
        send_range(10, 17, -1, 1'b0);
        drain();
        end_test("mask operand sequences", e0);

        e0 = errors;
        send_range(1, 17, 1, 1'b0);
        drain();
        end_test("random back-pressure", e0);

        // fill the pipe with the output held off
        e0 = errors;
        send_item(18, 2, 1'b0);
        send_item(19, 2, 1'b0);
        drive_item(tbl[20]);
        @(posedge clk_i);
        pexp = '0;
        pexp[tbl[20].av] = 1'b1;
        pexp[tbl[20].mv] = 1'b1;
        pexp[tbl[19].mv] = 1'b1;
        check_val("pipe_in_ready_o", 64'(pipe_in_ready_o), 64'd0);
        check_val("pending_vreg_reads_o", 64'(pending_vreg_reads_o), 64'(pexp));
        check_val("stage_valid_any_o", 64'(stage_valid_any_o), 64'd1);
        check_val("vreg_m_rd_addr_o", 64'(vreg_m_rd_addr_o), 64'(tbl[19].mv));
        @(negedge clk_i);
        send_item(20, 0, 1'b0);
        drain();
        end_test("full pipe and pending mask", e0);

        e0 = errors;
        send_range(1, 9, 0, 1'b1);
        drain();
        end_test("latency", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: unpack_stage_ctrl.sv
/*
 * unpack stage controller
 * stage valid and item registers, bubble-collapsing ready,
 * register read addressing and pending read mask
 */
module unpack_stage_ctrl import vregunpack_pkg::*; #(
    parameter int unsigned A_STAGE = 0,
    parameter int unsigned M_STAGE = 1
) (
    input  logic           clk_i,
    input  logic           async_rst_ni,
    input  logic           pipe_in_valid_i,
    output logic           pipe_in_ready_o,
    input  ctrl_t          pipe_in_ctrl_i,
    input  vsew_e          pipe_in_eew_i,
    input  a_flags_t       pipe_in_a_flags_i,
    input  m_flags_t       pipe_in_m_flags_i,
    input  vaddr_t         pipe_in_a_vaddr_i,
    input  vaddr_t         pipe_in_m_vaddr_i,
    input  xval_t          pipe_in_a_xval_i,
    output logic           pipe_out_valid_o,
    input  logic           pipe_out_ready_i,
    output ctrl_t          pipe_out_ctrl_o,
    output vaddr_t         vreg_a_rd_addr_o,
    input  vreg_data_t     vreg_a_rd_data_i,
    output vaddr_t         vreg_m_rd_addr_o,
    input  vreg_data_t     vreg_m_rd_data_i,
    output vreg_mask_t     pending_vreg_reads_o,
    output logic           stage_valid_any_o,
    op_lane_if.ctrl        a_lane,
    op_lane_if.ctrl        m_lane
);

    // index 0 is the input item, 1 and 2 are registered
    logic     [2:0] stage_valid;
    logic     [2:0] stage_ready;
    logic     [2:1] valid_q;
    ctrl_t    st_ctrl    [3];
    vsew_e    st_eew     [3];
    a_flags_t st_a_flags [3];
    m_flags_t st_m_flags [3];
    vaddr_t   st_a_vaddr [3];
    vaddr_t   st_m_vaddr [3];
    xval_t    st_a_xval  [3];
    ctrl_t    ctrl_q     [1:2];
    vsew_e    eew_q      [1:2];
    a_flags_t a_flags_q  [1:2];
    m_flags_t m_flags_q  [1:2];
    vaddr_t   a_vaddr_q  [1:2];
    vaddr_t   m_vaddr_q  [1:2];
    xval_t    a_xval_q   [1:2];

    always_comb begin
        stage_valid   = {valid_q, pipe_in_valid_i};
        st_ctrl[0]    = pipe_in_ctrl_i;
        st_eew[0]     = pipe_in_eew_i;
        st_a_flags[0] = pipe_in_a_flags_i;
        st_m_flags[0] = pipe_in_m_flags_i;
        st_a_vaddr[0] = pipe_in_a_vaddr_i;
        st_m_vaddr[0] = pipe_in_m_vaddr_i;
        st_a_xval[0]  = pipe_in_a_xval_i;
        for (int i = 1; i < 3; i++) begin
            st_ctrl[i]    = ctrl_q[i];
            st_eew[i]     = eew_q[i];
            st_a_flags[i] = a_flags_q[i];
            st_m_flags[i] = m_flags_q[i];
            st_a_vaddr[i] = a_vaddr_q[i];
            st_m_vaddr[i] = m_vaddr_q[i];
            st_a_xval[i]  = a_xval_q[i];
        end
    end

    // no stage stalls on its own, so an empty slot further down lets a stage move up
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            stage_ready[i] = pipe_out_ready_i;
            for (int j = i; j < 3; j++) begin
                if (!stage_valid[j]) begin
                    stage_ready[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= '0;
        end else begin
            for (int i = 1; i < 3; i++) begin
                if (stage_ready[i]) begin
                    valid_q[i] <= stage_valid[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 1; i < 3; i++) begin
            if (stage_ready[i] && stage_valid[i-1]) begin
                ctrl_q[i]    <= st_ctrl[i-1];
                eew_q[i]     <= st_eew[i-1];
                a_flags_q[i] <= st_a_flags[i-1];
                m_flags_q[i] <= st_m_flags[i-1];
                a_vaddr_q[i] <= st_a_vaddr[i-1];
                m_vaddr_q[i] <= st_m_vaddr[i-1];
                a_xval_q[i]  <= st_a_xval[i-1];
            end
        end
    end

    // each buffer loads in its load stage and extracts one stage later
    assign a_lane.load_en       = stage_valid[A_STAGE] & stage_ready[A_STAGE+1];
    assign a_lane.load_flags    = st_a_flags[A_STAGE];
    assign a_lane.load_eew      = st_eew[A_STAGE];
    assign a_lane.vreg_data     = vreg_a_rd_data_i;
    assign a_lane.extract_flags = st_a_flags[A_STAGE+1];
    assign a_lane.extract_eew   = st_eew[A_STAGE+1];
    assign a_lane.extract_xval  = st_a_xval[A_STAGE+1];
    assign a_lane.capture_en    = stage_valid[1] & stage_ready[2];

    assign m_lane.load_en       = stage_valid[M_STAGE] & stage_ready[M_STAGE+1];
    assign m_lane.load_flags    = a_flags_t'(st_m_flags[M_STAGE]);
    assign m_lane.load_eew      = st_eew[M_STAGE];
    assign m_lane.vreg_data     = vreg_m_rd_data_i;
    assign m_lane.extract_flags = a_flags_t'(st_m_flags[M_STAGE+1]);
    assign m_lane.extract_eew   = st_eew[M_STAGE+1];
    assign m_lane.extract_xval  = '0;
    assign m_lane.capture_en    = stage_valid[1] & stage_ready[2];

    // a broadcast scalar reads no register
    assign vreg_a_rd_addr_o = (stage_valid[A_STAGE] & st_a_flags[A_STAGE][A_LOAD] &
                               st_a_flags[A_STAGE][A_VREG]) ? st_a_vaddr[A_STAGE] : '0;
    assign vreg_m_rd_addr_o = (stage_valid[M_STAGE] & st_m_flags[M_STAGE][M_LOAD]) ?
                              st_m_vaddr[M_STAGE] : '0;

    // registers still to be read by items at or before their load stage
    always_comb begin
        pending_vreg_reads_o = '0;
        for (int i = 0; i < 3; i++) begin
            if (stage_valid[i] && i <= int'(A_STAGE) && st_a_flags[i][A_LOAD] &&
                st_a_flags[i][A_VREG]) begin
                pending_vreg_reads_o[st_a_vaddr[i]] = 1'b1;
            end
            if (stage_valid[i] && i <= int'(M_STAGE) && st_m_flags[i][M_LOAD]) begin
                pending_vreg_reads_o[st_m_vaddr[i]] = 1'b1;
            end
        end
    end

    assign pipe_in_ready_o   = stage_ready[0];
    assign pipe_out_valid_o  = stage_valid[2];
    assign pipe_out_ctrl_o   = st_ctrl[2];
    assign stage_valid_any_o = |stage_valid;

endmodule

// File: vregunpack_chk.sv
/*
 * output pipe and status checks for the vector register unpack pipeline
 */
module vregunpack_chk import vregunpack_pkg::*; (
    input logic       clk_i,
    input logic       async_rst_ni,
    input logic       pipe_out_valid_o,
    input logic       pipe_out_ready_i,
    input ctrl_t      pipe_out_ctrl_o,
    input op_data_t   pipe_out_a_data_o,
    input op_data_t   pipe_out_m_data_o,
    input vreg_mask_t pending_vreg_reads_o,
    input logic       stage_valid_any_o
);

    // a stalled output item holds still until it transfers
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        pipe_out_valid_o && !pipe_out_ready_i |=>
        pipe_out_valid_o && $stable(pipe_out_ctrl_o) &&
        $stable(pipe_out_a_data_o) && $stable(pipe_out_m_data_o))
        else $error("output changed while stalled");

    assert property (@(posedge clk_i) !async_rst_ni |-> !pipe_out_valid_o)
        else $error("output valid during reset");

    // an empty pipe reads no register
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !stage_valid_any_o |-> pending_vreg_reads_o == '0)
        else $error("pending reads with no valid stage");

endmodule

bind vregunpack_top vregunpack_chk u_chk (.*);

// File: vregunpack_pkg.sv
/*
 * vector register unpack package
 * widths, element width encoding and operand flag vectors
 */
package vregunpack_pkg;

    // datapath widths
    localparam int unsigned VREG_W    = 64;
    localparam int unsigned OP_W      = 32;
    localparam int unsigned VADDR_W   = 5;
    localparam int unsigned NUM_VREGS = 32;
    localparam int unsigned CTRL_W    = 8;

    typedef logic [VREG_W-1:0]    vreg_data_t;
    typedef logic [OP_W-1:0]      op_data_t;
    typedef logic [VADDR_W-1:0]   vaddr_t;
    typedef logic [CTRL_W-1:0]    ctrl_t;
    typedef logic [31:0]          xval_t;
    typedef logic [NUM_VREGS-1:0] vreg_mask_t;

    // element width of the current item
    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    // data operand flags
    typedef logic [4:0] a_flags_t;

    localparam int unsigned A_LOAD   = 0;
    localparam int unsigned A_SHIFT  = 1;
    localparam int unsigned A_NARROW = 2;
    localparam int unsigned A_SIGEXT = 3;
    // cleared when the operand is a broadcast scalar
    localparam int unsigned A_VREG   = 4;

    // mask operand flags
    typedef logic [1:0] m_flags_t;

    localparam int unsigned M_LOAD  = 0;
    localparam int unsigned M_SHIFT = 1;

endpackage

// File: vregunpack_top.sv
/*
 * vector register unpack pipeline
 * two-stage unpack of a data operand and a mask operand
 */
module vregunpack_top import vregunpack_pkg::*; #(
    parameter int unsigned A_STAGE = 0,
    parameter int unsigned M_STAGE = 1
) (
    input  logic       clk_i,
    input  logic       async_rst_ni,

    // input pipe
    input  logic       pipe_in_valid_i,
    output logic       pipe_in_ready_o,
    input  ctrl_t      pipe_in_ctrl_i,
    input  vsew_e      pipe_in_eew_i,
    input  a_flags_t   pipe_in_a_flags_i,
    input  m_flags_t   pipe_in_m_flags_i,
    input  vaddr_t     pipe_in_a_vaddr_i,
    input  vaddr_t     pipe_in_m_vaddr_i,
    input  xval_t      pipe_in_a_xval_i,

    // output pipe
    output logic       pipe_out_valid_o,
    input  logic       pipe_out_ready_i,
    output ctrl_t      pipe_out_ctrl_o,
    output op_data_t   pipe_out_a_data_o,
    output op_data_t   pipe_out_m_data_o,

    // register file read ports answered in the same cycle
    output vaddr_t     vreg_a_rd_addr_o,
    input  vreg_data_t vreg_a_rd_data_i,
    output vaddr_t     vreg_m_rd_addr_o,
    input  vreg_data_t vreg_m_rd_data_i,

    // status
    output vreg_mask_t pending_vreg_reads_o,
    output logic       stage_valid_any_o
);

    op_lane_if a_lane ();
    op_lane_if m_lane ();

    unpack_stage_ctrl #(
        .A_STAGE (A_STAGE),
        .M_STAGE (M_STAGE)
    ) u_ctrl (
        .clk_i                (clk_i),
        .async_rst_ni         (async_rst_ni),
        .pipe_in_valid_i      (pipe_in_valid_i),
        .pipe_in_ready_o      (pipe_in_ready_o),
        .pipe_in_ctrl_i       (pipe_in_ctrl_i),
        .pipe_in_eew_i        (pipe_in_eew_i),
        .pipe_in_a_flags_i    (pipe_in_a_flags_i),
        .pipe_in_m_flags_i    (pipe_in_m_flags_i),
        .pipe_in_a_vaddr_i    (pipe_in_a_vaddr_i),
        .pipe_in_m_vaddr_i    (pipe_in_m_vaddr_i),
        .pipe_in_a_xval_i     (pipe_in_a_xval_i),
        .pipe_out_valid_o     (pipe_out_valid_o),
        .pipe_out_ready_i     (pipe_out_ready_i),
        .pipe_out_ctrl_o      (pipe_out_ctrl_o),
        .vreg_a_rd_addr_o     (vreg_a_rd_addr_o),
        .vreg_a_rd_data_i     (vreg_a_rd_data_i),
        .vreg_m_rd_addr_o     (vreg_m_rd_addr_o),
        .vreg_m_rd_data_i     (vreg_m_rd_data_i),
        .pending_vreg_reads_o (pending_vreg_reads_o),
        .stage_valid_any_o    (stage_valid_any_o),
        .a_lane               (a_lane.ctrl),
        .m_lane               (m_lane.ctrl)
    );

    data_operand_unpack u_a_unpack (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .lane         (a_lane.lane)
    );

    mask_operand_unpack u_m_unpack (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .lane         (m_lane.lane)
    );

    assign pipe_out_a_data_o = a_lane.op_data;
    assign pipe_out_m_data_o = m_lane.op_data;

endmodule
